// File: common/usb_rx_pkg.sv
// Shared definitions for the USB receive handler behind a UTMI PHY.
// Tick limits assume a 60 MHz UTMI clock.
// CRC residues are for the left-shifting register fed LSB first from all ones.
package usb_rx_pkg;

    //////////////////////////////////////////////////
    // Basic field types
    //////////////////////////////////////////////////
    typedef logic [3:0]  pid_t;
    typedef logic [6:0]  dev_addr_t;
    typedef logic [3:0]  endp_t;
    typedef logic [1:0]  line_state_t;
    typedef logic [1:0]  pkt_kind_t;
    typedef logic [7:0]  byte_count_t;
    typedef logic [4:0]  crc5_t;
    typedef logic [15:0] crc16_t;
    typedef logic [19:0] line_ticks_t;   // Saturates at all ones

    // Token PIDs
    localparam pid_t PID_OUT   = 4'b0001;
    localparam pid_t PID_IN    = 4'b1001;
    localparam pid_t PID_SETUP = 4'b1101;
    localparam pid_t PID_PING  = 4'b0100;
    localparam pid_t PID_SOF   = 4'b0101;
    // Data PIDs
    localparam pid_t PID_DATA0 = 4'b0011;
    localparam pid_t PID_DATA1 = 4'b1011;
    localparam pid_t PID_DATA2 = 4'b0111;
    localparam pid_t PID_MDATA = 4'b1111;
    // Handshake PIDs
    localparam pid_t PID_ACK   = 4'b0010;
    localparam pid_t PID_NAK   = 4'b1010;
    localparam pid_t PID_STALL = 4'b1110;
    localparam pid_t PID_NYET  = 4'b0110;

    localparam line_state_t LINE_SE0 = 2'b00;
    localparam line_state_t LINE_J   = 2'b01;
    localparam line_state_t LINE_K   = 2'b10;

    localparam pkt_kind_t KIND_TOKEN     = 2'd0;
    localparam pkt_kind_t KIND_DATA      = 2'd1;
    localparam pkt_kind_t KIND_HANDSHAKE = 2'd2;
    localparam pkt_kind_t KIND_OTHER     = 2'd3;

    localparam line_ticks_t RESET_TICKS   = 20'd150;      // 2.5 us
    localparam line_ticks_t SUSPEND_TICKS = 20'd180000;   // 3 ms

    localparam crc5_t  CRC5_POLY     = 5'h05;     // x^5 + x^2 + 1
    localparam crc16_t CRC16_POLY    = 16'h8005;  // x^16 + x^15 + x^2 + 1
    localparam crc5_t  CRC5_RESIDUE  = 5'h0C;
    localparam crc16_t CRC16_RESIDUE = 16'h800D;

    //////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       active;
        logic       error;
    } utmi_rx_t;

    typedef struct packed {
        logic [7:0] data;
        logic       sop;     // PID byte only
    } rx_byte_t;

    typedef struct packed {
        pkt_kind_t   kind;
        pid_t        pid;
        logic        pid_ok;
        dev_addr_t   dev_addr;
        endp_t       endp;
        logic        crc_ok;
        logic        rx_err;
        byte_count_t byte_count;   // Includes the PID byte
    } pkt_result_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PID,
        ST_TOKEN,
        ST_DATA,
        ST_WAIT_EOP,
        ST_DRAIN
    } rx_state_e;

    // PID group lookup
    function automatic pkt_kind_t pid_kind(input pid_t pid);
        case (pid)
            PID_OUT, PID_IN, PID_SETUP, PID_PING, PID_SOF: return KIND_TOKEN;
            PID_DATA0, PID_DATA1, PID_DATA2, PID_MDATA:    return KIND_DATA;
            PID_ACK, PID_NAK, PID_STALL, PID_NYET:         return KIND_HANDSHAKE;
            default:                                       return KIND_OTHER;
        endcase
    endfunction

endpackage

// File: packet_rx/crc_check.sv
// Serial CRC5 and CRC16 over whole bytes, LSB first, from all ones.
// The ok flags compare against the residue of a good packet, so the
// received CRC bytes must be strobed in like any other byte.
module crc_check (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       strobe,
    input  logic [7:0] data,
    output logic       crc5_ok,
    output logic       crc16_ok
);
    import usb_rx_pkg::*;

    crc5_t  crc5_q;
    crc16_t crc16_q;
    crc5_t  crc5_d;
    crc16_t crc16_d;
    logic   fb5;
    logic   fb16;

    //////////////////////////////////////////////////
    // Both registers advance together, bit by bit
    //////////////////////////////////////////////////
    always_comb begin
        crc5_d  = crc5_q;
        crc16_d = crc16_q;
        fb5     = 1'b0;
        fb16    = 1'b0;
        for (int i = 0; i < 8; i++) begin
            fb5     = data[i] ^ crc5_d[4];
            fb16    = data[i] ^ crc16_d[15];
            crc5_d  = {crc5_d[3:0], 1'b0} ^ ({5{fb5}} & CRC5_POLY);
            crc16_d = {crc16_d[14:0], 1'b0} ^ ({16{fb16}} & CRC16_POLY);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc5_q  <= '1;
            crc16_q <= '1;
        end else if (clear) begin
            crc5_q  <= '1;   // New packet
            crc16_q <= '1;
        end else if (strobe) begin
            crc5_q  <= crc5_d;
            crc16_q <= crc16_d;
        end
    end

    assign crc5_ok  = (crc5_q == CRC5_RESIDUE);
    assign crc16_ok = (crc16_q == CRC16_RESIDUE);

    // The FSM clears on the PID byte and strobes only later bytes
    a_clear_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(clear && strobe));

endmodule

// File: packet_rx/rx_packet_fsm.sv
// Follows each received packet and builds one result per packet.
// A byte is taken when valid and active are both high.
// An error ends the packet at once; bytes up to the next idle gap are dropped.
// Packets need at least one cycle of active low between them.
module rx_packet_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  usb_rx_pkg::utmi_rx_t     utmi,
    input  logic                     crc5_ok,
    input  logic                     crc16_ok,
    output logic                     crc_clear,
    output logic                     crc_strobe,
    output logic [7:0]               crc_byte,
    output usb_rx_pkg::rx_byte_t     rx_byte,
    output logic                     byte_valid,
    output usb_rx_pkg::pkt_result_t  result,
    output logic                     result_valid
);
    import usb_rx_pkg::*;

    rx_state_e   state;
    pid_t        pid_q;
    pkt_kind_t   kind_q;
    logic        pid_ok_q;
    dev_addr_t   addr_q;
    endp_t       endp_q;
    byte_count_t cnt_q;

    logic accept;
    logic in_pkt;
    logic start;
    logic take;
    logic pkt_end;
    logic crc_ok;

    assign accept  = utmi.valid && utmi.active;
    assign in_pkt  = (state != ST_IDLE) && (state != ST_DRAIN);
    assign start   = accept && !utmi.error && (state == ST_IDLE);   // PID byte
    assign take    = accept && !utmi.error && in_pkt;               // Any later byte
    assign pkt_end = in_pkt && (utmi.error || !utmi.active);

    // CRC runs alongside the byte being accepted
    assign crc_clear  = start;
    assign crc_strobe = take;
    assign crc_byte   = utmi.data;

    always_comb begin
        case (kind_q)
            KIND_TOKEN: crc_ok = crc5_ok && (cnt_q == byte_count_t'(3));
            KIND_DATA:  crc_ok = crc16_ok;
            default:    crc_ok = 1'b1;   // Nothing to check
        endcase
        if (utmi.error) begin
            crc_ok = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            byte_valid   <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            byte_valid   <= start || take;
            result_valid <= pkt_end;
            case (state)
                ST_IDLE: begin
                    if (utmi.error && utmi.active) begin
                        state <= ST_DRAIN;   // Broken packet with no PID
                    end else if (start) begin
                        state <= ST_PID;
                    end
                end
                ST_DRAIN: begin
                    if (!utmi.active) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    if (pkt_end) begin
                        state <= (utmi.error && utmi.active) ? ST_DRAIN : ST_IDLE;
                    end else if (take) begin
                        case (state)
                            ST_PID: begin
                                if (kind_q == KIND_TOKEN) state <= ST_TOKEN;
                                else if (kind_q == KIND_DATA) state <= ST_DATA;
                                else state <= ST_WAIT_EOP;
                            end
                            ST_TOKEN: state <= ST_WAIT_EOP;   // Second token byte
                            default:  state <= state;
                        endcase
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Packet fields
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (start || take) begin
            rx_byte <= '{data: utmi.data, sop: start};
        end
        if (start) begin
            pid_q    <= utmi.data[3:0];
            kind_q   <= pid_kind(utmi.data[3:0]);
            pid_ok_q <= (utmi.data[7:4] == ~utmi.data[3:0]);
            addr_q   <= '0;
            endp_q   <= '0;
            cnt_q    <= byte_count_t'(1);
        end else if (take) begin
            if (cnt_q != '1) begin
                cnt_q <= cnt_q + 1'b1;   // Saturates on long packets
            end
        end
        // Token layout: {endp[0], addr} then {crc5, endp[3:1]}
        if (take && (state == ST_PID) && (kind_q == KIND_TOKEN)) begin
            addr_q    <= utmi.data[6:0];
            endp_q[0] <= utmi.data[7];
        end
        if (take && (state == ST_TOKEN)) begin
            endp_q[3:1] <= utmi.data[2:0];
        end
        if (pkt_end) begin
            result <= '{kind:       kind_q,
                        pid:        pid_q,
                        pid_ok:     pid_ok_q,
                        dev_addr:   addr_q,
                        endp:       endp_q,
                        crc_ok:     crc_ok,
                        rx_err:     utmi.error,
                        byte_count: cnt_q};
        end
    end

    // One result per packet, and nothing forwarded between packets
    a_result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid);
    a_no_byte_idle: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |-> (state != ST_IDLE));

endmodule

// File: line_mon/line_state_timer.sv
// Measures how long the UTMI line state has been stable.
// Count is zero in the first cycle after a change and saturates at all ones.
module line_state_timer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  usb_rx_pkg::line_state_t  line_state,
    output usb_rx_pkg::line_ticks_t  ticks,
    output logic                     changed,
    output usb_rx_pkg::line_state_t  held_state
);
    import usb_rx_pkg::*;

    logic differs;

    assign differs = (line_state != held_state);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_state <= LINE_J;   // Idle bus
            ticks      <= '0;
            changed    <= 1'b0;
        end else begin
            held_state <= line_state;
            changed    <= differs;
            if (differs) begin
                ticks <= '0;
            end else if (ticks != '1) begin
                ticks <= ticks + 1'b1;
            end
        end
    end

endmodule

// File: line_mon/bus_event_detect.sv
// Bus reset, suspend and resume flags from the held line state.
// bus_reset follows SE0 once it passes RESET_TICKS and drops when SE0 ends.
// suspend is sticky until K or SE0; resume is a single-cycle pulse on K.
module bus_event_detect (
    input  logic                     clk,
    input  logic                     rst_n,
    input  usb_rx_pkg::line_ticks_t  ticks,
    input  logic                     changed,
    input  usb_rx_pkg::line_state_t  held_state,
    output logic                     bus_reset,
    output logic                     suspend,
    output logic                     resume
);
    import usb_rx_pkg::*;

    logic se0_long;
    logic j_long;
    logic wake;

    // ticks is one behind the number of cycles held
    assign se0_long = (held_state == LINE_SE0) && (ticks >= RESET_TICKS - 1'b1);
    assign j_long   = (held_state == LINE_J) && (ticks >= SUSPEND_TICKS - 1'b1);
    assign wake     = changed && ((held_state == LINE_K) || (held_state == LINE_SE0));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_reset <= 1'b0;
            suspend   <= 1'b0;
            resume    <= 1'b0;
        end else begin
            bus_reset <= se0_long;
            resume    <= suspend && changed && (held_state == LINE_K);
            if (wake) begin
                suspend <= 1'b0;
            end else if (j_long) begin
                suspend <= 1'b1;
            end
        end
    end

    // Resume only ever ends a suspend
    a_resume_after_suspend: assert property (@(posedge clk) disable iff (!rst_n)
        resume |-> $past(suspend) && !suspend);

endmodule

// File: rtl/usb_rx_top.sv
// Receive side of a USB protocol handler behind a UTMI PHY.
// Outputs carry no back-pressure; the consumer must take them every cycle.
// Address matching is left to the consumer of the results.
module usb_rx_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  usb_rx_pkg::utmi_rx_t      utmi,
    input  usb_rx_pkg::line_state_t  line_state,
    output usb_rx_pkg::rx_byte_t      rx_byte,
    output logic                      byte_valid,
    output usb_rx_pkg::pkt_result_t   result,
    output logic                      result_valid,
    output logic                      bus_reset,
    output logic                      suspend,
    output logic                      resume
);
    import usb_rx_pkg::*;

    logic        crc_clear;
    logic        crc_strobe;
    logic [7:0]  crc_byte;
    logic        crc5_ok;
    logic        crc16_ok;

    line_ticks_t ticks;
    logic        changed;
    line_state_t held_state;

    //////////////////////////////////////////////////
    // Packet path
    //////////////////////////////////////////////////
    rx_packet_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .utmi         (utmi),
        .crc5_ok      (crc5_ok),
        .crc16_ok     (crc16_ok),
        .crc_clear    (crc_clear),
        .crc_strobe   (crc_strobe),
        .crc_byte     (crc_byte),
        .rx_byte      (rx_byte),
        .byte_valid   (byte_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    crc_check u_crc (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (crc_clear),
        .strobe   (crc_strobe),
        .data     (crc_byte),
        .crc5_ok  (crc5_ok),
        .crc16_ok (crc16_ok)
    );

    //////////////////////////////////////////////////
    // Line monitor
    //////////////////////////////////////////////////
    line_state_timer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .line_state (line_state),
        .ticks      (ticks),
        .changed    (changed),
        .held_state (held_state)
    );

    bus_event_detect u_events (
        .clk        (clk),
        .rst_n      (rst_n),
        .ticks      (ticks),
        .changed    (changed),
        .held_state (held_state),
        .bus_reset  (bus_reset),
        .suspend    (suspend),
        .resume     (resume)
    );

endmodule

// File: testbench/tb_checks.svh
// Compare tasks and the fail routine, included inside the tb_usb_rx module body.
// The first failed check ends the run through $fatal.
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at the first failed check");
endtask

// One line per result, field by field
function automatic string describe_result(input pkt_result_t r);
    return $sformatf("kind=%0d pid=%h pid_ok=%b addr=%h endp=%h crc_ok=%b rx_err=%b count=%0d",
                     r.kind, r.pid, r.pid_ok, r.dev_addr, r.endp, r.crc_ok, r.rx_err,
                     r.byte_count);
endfunction

task automatic check_byte(input rx_byte_t got, input rx_byte_t exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH at %0t: rx_byte got data=%h sop=%b expected data=%h sop=%b",
                           $time, got.data, got.sop, exp.data, exp.sop));
    end
endtask

task automatic check_result(input pkt_result_t got, input pkt_result_t exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH at %0t: result got {%s} expected {%s}",
                           $time, describe_result(got), describe_result(exp)));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        fail_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
endtask

`endif

// File: testbench/tb_usb_rx.sv
// Testbench for usb_rx_top with seeded random packets and line-state sequences.
// Expected bytes and results come from a model of the USB packet rules.
// The suspend test holds J for SUSPEND_TICKS cycles, so the run is long.
module tb_usb_rx;
    import usb_rx_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int N_TOKEN      = 40;
    localparam int N_BAD_TOKEN  = 20;
    localparam int N_DATA       = 60;
    localparam int N_SHORT_PKT  = 20;
    localparam int N_ERR_PKT    = 15;
    localparam int N_SHORT_SE0  = 6;
    localparam int PKT_CYCLES   = 70;   // Worst case for one packet with gaps
    localparam int PKT_COUNT    = N_TOKEN + N_BAD_TOKEN + N_DATA + N_SHORT_PKT + 2 * N_ERR_PKT;
    localparam int LINE_CYCLES  = N_SHORT_SE0 * (int'(RESET_TICKS) + 20)
                                  + int'(RESET_TICKS) + int'(SUSPEND_TICKS) + 200;
    localparam int STIM_CYCLES  = RESET_CYCLES + PKT_COUNT * PKT_CYCLES + LINE_CYCLES;

    logic        clk;
    logic        rst_n;
    utmi_rx_t    utmi;
    line_state_t line_state;
    rx_byte_t    rx_byte;
    logic        byte_valid;
    pkt_result_t result;
    logic        result_valid;
    logic        bus_reset;
    logic        suspend;
    logic        resume;

    int          seed;
    logic [7:0]  pkt[$];          // Packet being built, PID first
    rx_byte_t    exp_bytes[$];
    pkt_result_t exp_results[$];
    logic        guard_reset;     // bus_reset must stay low while set
    int          resume_count;

    pid_t token_pids[5] = '{PID_OUT, PID_IN, PID_SETUP, PID_PING, PID_SOF};
    pid_t data_pids[4]  = '{PID_DATA0, PID_DATA1, PID_DATA2, PID_MDATA};
    pid_t hs_pids[4]    = '{PID_ACK, PID_NAK, PID_STALL, PID_NYET};

    `include "tb_checks.svh"

    usb_rx_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .utmi         (utmi),
        .line_state   (line_state),
        .rx_byte      (rx_byte),
        .byte_valid   (byte_valid),
        .result       (result),
        .result_valid (result_valid),
        .bus_reset    (bus_reset),
        .suspend      (suspend),
        .resume       (resume)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // Model of the packet rules
    //////////////////////////////////////////////////
    function automatic int rand_range(input int lo, input int hi);
        int unsigned r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    function automatic pkt_kind_t kind_of(input pid_t p);
        if (p inside {PID_OUT, PID_IN, PID_SETUP, PID_PING, PID_SOF}) return KIND_TOKEN;
        if (p inside {PID_DATA0, PID_DATA1, PID_DATA2, PID_MDATA}) return KIND_DATA;
        if (p inside {PID_ACK, PID_NAK, PID_STALL, PID_NYET}) return KIND_HANDSHAKE;
        return KIND_OTHER;
    endfunction

    // LSB first, one bit per step
    function automatic crc5_t crc5_feed(input crc5_t c, input logic [7:0] d, input int nbits);
        crc5_t r;
        logic  msb;
        r = c;
        for (int i = 0; i < nbits; i++) begin
            msb = r[4];
            r = {r[3:0], 1'b0};
            if (msb != d[i]) begin
                r = r ^ CRC5_POLY;
            end
        end
        return r;
    endfunction

    function automatic crc16_t crc16_feed(input crc16_t c, input logic [7:0] d);
        crc16_t r;
        logic   msb;
        r = c;
        for (int i = 0; i < 8; i++) begin
            msb = r[15];
            r = {r[14:0], 1'b0};
            if (msb != d[i]) begin
                r = r ^ CRC16_POLY;
            end
        end
        return r;
    endfunction

    // Token bytes {endp[0], addr} then {~crc5 sent MSB first, endp[3:1]}
    task automatic build_token(input pid_t pid, input dev_addr_t addr, input endp_t endp);
        crc5_t      c;
        logic [7:0] b1;
        b1 = {endp[0], addr};
        c = crc5_feed(5'h1F, b1, 8);
        c = crc5_feed(c, {5'b0, endp[3:1]}, 3);   // 11 bits in all
        pkt.delete();
        pkt.push_back({~pid, pid});
        pkt.push_back(b1);
        pkt.push_back({~c[0], ~c[1], ~c[2], ~c[3], ~c[4], endp[3:1]});
    endtask

    task automatic build_data(input pid_t pid, input int len);
        crc16_t      c;
        logic [15:0] tail;
        pkt.delete();
        pkt.push_back({~pid, pid});
        c = 16'hFFFF;
        for (int i = 0; i < len; i++) begin
            pkt.push_back(8'($random(seed)));
            c = crc16_feed(c, pkt[i + 1]);
        end
        for (int i = 0; i < 16; i++) begin
            tail[i] = ~c[15 - i];   // Inverted CRC, MSB goes out first
        end
        pkt.push_back(tail[7:0]);
        pkt.push_back(tail[15:8]);
    endtask

    // Queues what the DUT must forward and report for pkt
    task automatic expect_packet(input int err_at);
        int          n;
        rx_byte_t    b;
        pkt_result_t r;
        crc5_t       c5;
        crc16_t      c16;
        n = (err_at >= 0) ? err_at : pkt.size();
        c5 = 5'h1F;
        c16 = 16'hFFFF;
        for (int i = 0; i < n; i++) begin
            b.data = pkt[i];
            b.sop = (i == 0);
            exp_bytes.push_back(b);
            if (i > 0) begin
                c5 = crc5_feed(c5, pkt[i], 8);
                c16 = crc16_feed(c16, pkt[i]);
            end
        end
        r = '0;
        r.pid = pkt[0][3:0];
        r.kind = kind_of(r.pid);
        r.pid_ok = (pkt[0][7:4] == ~pkt[0][3:0]);
        r.byte_count = byte_count_t'(n);
        if (r.kind == KIND_TOKEN && n > 1) begin
            r.dev_addr = pkt[1][6:0];
            r.endp[0] = pkt[1][7];
        end
        if (r.kind == KIND_TOKEN && n > 2) begin
            r.endp[3:1] = pkt[2][2:0];
        end
        case (r.kind)
            KIND_TOKEN: r.crc_ok = (n == 3) && (c5 == CRC5_RESIDUE);
            KIND_DATA:  r.crc_ok = (c16 == CRC16_RESIDUE);
            default:    r.crc_ok = 1'b1;
        endcase
        if (err_at >= 0) begin
            r.crc_ok = 1'b0;
            r.rx_err = 1'b1;
        end
        exp_results.push_back(r);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic drive_utmi(input logic [7:0] d, input logic v, input logic a, input logic e);
        @(posedge clk);
        utmi <= '{data: d, valid: v, active: a, error: e};
    endtask

    task automatic send_packet(input int err_at);
        int n;
        n = (err_at >= 0) ? err_at : pkt.size();
        for (int i = 0; i < n; i++) begin
            drive_utmi(pkt[i], 1'b1, 1'b1, 1'b0);
            repeat (rand_range(0, 2)) begin
                drive_utmi(8'h00, 1'b0, 1'b1, 1'b0);   // PHY gap inside the packet
            end
        end
        if (err_at >= 0) begin
            drive_utmi(pkt[err_at], 1'b1, 1'b1, 1'b1);
            repeat (2) begin
                drive_utmi(pkt[err_at], 1'b1, 1'b1, 1'b0);   // Dropped while draining
            end
        end
        repeat (rand_range(1, 3)) begin
            drive_utmi(8'h00, 1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic run_packet(input int err_at);
        expect_packet(err_at);
        send_packet(err_at);
    endtask

    task automatic run_packet_tests;
        int   idx;
        pid_t p;
        for (int k = 0; k < N_TOKEN; k++) begin
            build_token(token_pids[rand_range(0, 4)], dev_addr_t'($random(seed)),
                        endp_t'($random(seed)));
            run_packet(-1);
        end
        for (int k = 0; k < N_BAD_TOKEN; k++) begin
            build_token(token_pids[rand_range(0, 4)], dev_addr_t'($random(seed)),
                        endp_t'($random(seed)));
            if (rand_range(0, 1) == 1) begin
                pkt[2] = pkt[2] ^ (8'h01 << rand_range(3, 7));   // CRC5 field
            end else begin
                pkt[0] = pkt[0] ^ (8'h10 << rand_range(0, 3));   // PID check nibble
            end
            run_packet(-1);
        end
        for (int k = 0; k < N_DATA; k++) begin
            build_data(data_pids[rand_range(0, 3)], rand_range(0, 16));
            if (rand_range(0, 1) == 1) begin
                idx = rand_range(1, pkt.size() - 1);
                pkt[idx] = pkt[idx] ^ (8'h01 << rand_range(0, 7));
            end
            run_packet(-1);
        end
        // Handshakes and lone PIDs of any code
        for (int k = 0; k < N_SHORT_PKT; k++) begin
            p = (k % 2 == 0) ? hs_pids[rand_range(0, 3)] : pid_t'(rand_range(0, 15));
            pkt.delete();
            pkt.push_back({~p, p});
            run_packet(-1);
        end
        for (int k = 0; k < N_ERR_PKT; k++) begin
            build_data(data_pids[rand_range(0, 3)], rand_range(0, 16));
            run_packet(rand_range(1, pkt.size() - 1));
            build_data(data_pids[rand_range(0, 3)], rand_range(0, 16));
            run_packet(-1);   // Clean packet right after the broken one
        end
    endtask

    task automatic hold_line(input line_state_t s, input int cycles);
        @(posedge clk);
        line_state <= s;
        repeat (cycles - 1) @(posedge clk);
    endtask

    task automatic run_line_tests;
        int base;
        guard_reset = 1'b1;
        for (int k = 0; k < N_SHORT_SE0; k++) begin
            if (k == 0) begin
                hold_line(LINE_SE0, int'(RESET_TICKS) - 1);   // Longest SE0 still too short
            end else begin
                hold_line(LINE_SE0, rand_range(1, int'(RESET_TICKS) - 1));
            end
            hold_line(LINE_J, rand_range(4, 20));
        end
        guard_reset = 1'b0;
        hold_line(LINE_SE0, int'(RESET_TICKS) + 3);
        @(negedge clk);
        check_flag("bus_reset", bus_reset, 1'b1);
        hold_line(LINE_J, 3);
        @(negedge clk);
        check_flag("bus_reset", bus_reset, 1'b0);
        check_flag("suspend", suspend, 1'b0);
        hold_line(LINE_J, int'(SUSPEND_TICKS));   // J now held SUSPEND_TICKS+3 cycles
        @(negedge clk);
        check_flag("suspend", suspend, 1'b1);
        @(posedge clk);
        base = resume_count;
        hold_line(LINE_K, rand_range(3, 10));
        hold_line(LINE_J, rand_range(5, 20));
        @(negedge clk);
        check_flag("suspend", suspend, 1'b0);
        @(posedge clk);
        check_count("resume pulses", resume_count - base, 1);
    endtask

    //////////////////////////////////////////////////
    // Monitor, watchdog and verdict
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n && byte_valid) begin
            if (exp_bytes.size() == 0) begin
                fail_run("DUT forwarded a byte that the model did not expect");
            end else begin
                check_byte(rx_byte, exp_bytes.pop_front());
            end
        end
        if (rst_n && result_valid) begin
            if (exp_results.size() == 0) begin
                fail_run("DUT delivered a result that the model did not expect");
            end else begin
                check_result(result, exp_results.pop_front());
            end
        end
        if (guard_reset) begin
            check_flag("bus_reset", bus_reset, 1'b0);
        end
        if (rst_n && resume) begin
            resume_count = resume_count + 1;
        end
    end

    initial begin
        repeat (STIM_CYCLES + 1000) @(posedge clk);
        fail_run("Watchdog expired before the tests finished");
    end

    initial begin
        seed = 15;
        guard_reset = 1'b0;
        resume_count = 0;
        rst_n <= 1'b0;
        utmi <= '0;
        line_state <= LINE_J;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("byte_valid", byte_valid, 1'b0);
        check_flag("result_valid", result_valid, 1'b0);
        check_flag("bus_reset", bus_reset, 1'b0);
        check_flag("suspend", suspend, 1'b0);
        check_flag("resume", resume, 1'b0);
        run_packet_tests();
        run_line_tests();
        repeat (10) @(posedge clk);
        if (exp_bytes.size() != 0 || exp_results.size() != 0) begin
            fail_run($sformatf("Run ended with %0d bytes and %0d results never delivered",
                               exp_bytes.size(), exp_results.size()));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: all.f
+incdir+testbench
common/usb_rx_pkg.sv
packet_rx/crc_check.sv
packet_rx/rx_packet_fsm.sv
line_mon/line_state_timer.sv
line_mon/bus_event_detect.sv
rtl/usb_rx_top.sv
testbench/tb_usb_rx.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_usb_rx
FILELIST := all.f
BUILD    := obj_dir
PASS_MSG := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
